//--- rtl/eth_frame_pkg.sv
package eth_frame_pkg;

   // MII framing
   localparam int PREAMBLE_NIBBLES = 15;      // 0x5 nibbles ahead of the delimiter
   localparam logic [3:0] SFD_NIBBLE = 4'hD;
   localparam int FCS_BYTES = 4;

   // CRC-32 register kept MSB first with data bits fed LSB first
   localparam logic [31:0] CRC_POLY    = 32'h04C1_1DB7;
   localparam logic [31:0] CRC_INIT    = 32'hFFFF_FFFF;
   localparam logic [31:0] CRC_RESIDUE = 32'hC704_DD7B;  // Register after a good FCS

   // Byte address width of a 2 KiB buffer
   localparam int BUF_ADDR_W = 11;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_PREAMBLE,
      TX_DATA,
      TX_FCS
   } tx_state_t;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_PREAMBLE,
      RX_DATA,
      RX_HOLD        // Frame kept until the host acks
   } rx_state_t;

endpackage

//--- rtl/eth_csr_pkg.sv
package eth_csr_pkg;

   localparam int WB_ADR_W = 12;

   // Address bit 11 steers writes to TX and reads to RX
   localparam int BUF_WINDOW_BIT = 11;

   typedef enum logic [WB_ADR_W-1:0] {
      CSR_CTRL      = 12'h000,
      CSR_TX_NBYTES = 12'h004,
      CSR_STATUS    = 12'h008
   } csr_addr_t;

   // Writing 1 to a CTRL bit triggers its action
   localparam int CTRL_SEND_BIT = 0;
   localparam int CTRL_ACK_BIT  = 1;

   // STATUS bits
   localparam int STAT_TX_READY = 0;
   localparam int STAT_RX_RCVD  = 1;
   localparam int STAT_CRC_ERR  = 2;
   localparam int STAT_DV_SEEN  = 3;
   localparam int STAT_SIZE_LSB = 16;   // 11-bit received size

endpackage

//--- rtl/eth_crc32.sv
`timescale 1ns/1ps

module eth_crc32 (
   input  logic        MRxClk,
   input  logic        ETH_PHY_RESETN,
   input  logic        init_i,
   input  logic        en_i,
   input  logic [3:0]  nibble_i,
   output logic [31:0] crc_o,
   output logic        residue_ok_o
);
   import eth_frame_pkg::*;

   logic [31:0] crc_q;

   // One nibble with bit 0 entering first
   function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [3:0] nib);
      logic [31:0] c;
      logic        fb;
      c = crc;
      for (int i = 0; i < 4; i++) begin
         fb = c[31] ^ nib[i];
         c  = {c[30:0], 1'b0} ^ (fb ? CRC_POLY : 32'h0);
      end
      return c;
   endfunction

   always_ff @(posedge MRxClk or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) crc_q <= CRC_INIT;
      else if (init_i) crc_q <= CRC_INIT;
      else if (en_i) crc_q <= crc_step(crc_q, nibble_i);
   end

   // Reflected view so the FCS is ~crc_o sent low nibble first
   assign crc_o        = {<<{crc_q}};
   assign residue_ok_o = (crc_q == CRC_RESIDUE);

endmodule

//--- rtl/eth_buffer_ram.sv
`timescale 1ns/1ps

module eth_buffer_ram (
   input  logic                                 MRxClk,
   input  logic                                 wr_en_i,
   input  logic [3:0]                           wr_be_i,
   input  logic [eth_frame_pkg::BUF_ADDR_W-3:0] wr_addr_i,
   input  logic [31:0]                          wr_data_i,
   input  logic [eth_frame_pkg::BUF_ADDR_W-3:0] rd_addr_i,
   output logic [31:0]                          rd_data_o
);
   import eth_frame_pkg::*;

   logic [31:0] mem [2**(BUF_ADDR_W-2)];   // 512 words

   always_ff @(posedge MRxClk) begin
      if (wr_en_i) begin
         for (int b = 0; b < 4; b++) begin
            if (wr_be_i[b]) mem[wr_addr_i][8*b +: 8] <= wr_data_i[8*b +: 8];
         end
      end
   end

   always_ff @(posedge MRxClk) begin
      rd_data_o <= mem[rd_addr_i];
   end

endmodule

//--- rtl/eth_tx.sv
`timescale 1ns/1ps

module eth_tx (
   input  logic                                 MRxClk,
   input  logic                                 ETH_PHY_RESETN,
   input  logic                                 send_i,
   input  logic [eth_frame_pkg::BUF_ADDR_W-1:0] nbytes_i,
   output logic                                 ready_o,
   output logic [eth_frame_pkg::BUF_ADDR_W-3:0] buf_addr_o,
   input  logic [31:0]                          buf_data_i,
   output logic [3:0]                           mtxd_o,
   output logic                                 mtx_en_o
);
   import eth_frame_pkg::*;

   tx_state_t             state_q;
   logic [3:0]            cnt_q;        // Preamble and FCS nibble count, bit 0 is the data phase
   logic [BUF_ADDR_W-1:0] byte_idx_q;
   logic [3:0]            hi_nib_q;
   logic [7:0]            lane_byte;
   logic [3:0]            data_nib;
   logic [31:0]           crc;

   // Word of the next byte is fetched while the high nibble goes out
   assign buf_addr_o = byte_idx_q[BUF_ADDR_W-1:2];
   assign lane_byte  = buf_data_i[8*byte_idx_q[1:0] +: 8];
   assign data_nib   = cnt_q[0] ? hi_nib_q : lane_byte[3:0];

   eth_crc32 i_crc (
      .MRxClk        (MRxClk),
      .ETH_PHY_RESETN(ETH_PHY_RESETN),
      .init_i        (state_q == TX_IDLE),
      .en_i          (state_q == TX_DATA),
      .nibble_i      (data_nib),
      .crc_o         (crc),
      .residue_ok_o  ()
   );

   always_ff @(posedge MRxClk or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         state_q    <= TX_IDLE;
         cnt_q      <= '0;
         byte_idx_q <= '0;
         hi_nib_q   <= '0;
         ready_o    <= 1'b1;
         mtx_en_o   <= 1'b0;
         mtxd_o     <= '0;
      end else begin
         case (state_q)
            TX_IDLE: begin
               mtx_en_o   <= 1'b0;
               mtxd_o     <= '0;
               cnt_q      <= '0;
               byte_idx_q <= '0;
               ready_o    <= !mtx_en_o && !send_i;   // Back up one cycle after the frame
               if (send_i) state_q <= TX_PREAMBLE;
            end
            TX_PREAMBLE: begin
               mtx_en_o <= 1'b1;
               cnt_q    <= cnt_q + 1'b1;
               if (cnt_q == 4'(PREAMBLE_NIBBLES)) begin
                  mtxd_o  <= SFD_NIBBLE;
                  state_q <= TX_DATA;   // cnt_q wraps to 0
               end else begin
                  mtxd_o <= 4'h5;
               end
            end
            TX_DATA: begin
               mtxd_o <= data_nib;
               cnt_q  <= {3'b000, ~cnt_q[0]};
               if (!cnt_q[0]) begin
                  hi_nib_q   <= lane_byte[7:4];
                  byte_idx_q <= byte_idx_q + 1'b1;
               end else if (byte_idx_q == nbytes_i) begin
                  state_q <= TX_FCS;
               end
            end
            TX_FCS: begin
               mtxd_o <= ~crc[4*cnt_q[2:0] +: 4];
               cnt_q  <= cnt_q + 1'b1;
               if (cnt_q == 4'(2*FCS_BYTES-1)) state_q <= TX_IDLE;
            end
            default: state_q <= TX_IDLE;
         endcase
      end
   end

endmodule

//--- rtl/eth_rx.sv
`timescale 1ns/1ps

module eth_rx (
   input  logic                                 MRxClk,
   input  logic                                 ETH_PHY_RESETN,
   input  logic [3:0]                           mrxd_i,
   input  logic                                 mrx_dv_i,
   input  logic                                 ack_i,
   output logic                                 wr_en_o,
   output logic [3:0]                           wr_be_o,
   output logic [eth_frame_pkg::BUF_ADDR_W-3:0] wr_addr_o,
   output logic [31:0]                          wr_data_o,
   output logic                                 rcvd_o,
   output logic                                 crc_err_o,
   output logic                                 dv_seen_o,
   output logic [eth_frame_pkg::BUF_ADDR_W-1:0] size_o
);
   import eth_frame_pkg::*;

   rx_state_t             state_q;
   logic [3:0]            rxd_q;
   logic                  dv_q;
   logic                  dv_d;         // For the rising edge of data valid
   logic [3:0]            lo_nib_q;
   logic                  hi_phase_q;
   logic [BUF_ADDR_W-1:0] byte_cnt_q;
   logic                  residue_ok;

   eth_crc32 i_crc (
      .MRxClk        (MRxClk),
      .ETH_PHY_RESETN(ETH_PHY_RESETN),
      .init_i        (state_q == RX_PREAMBLE),
      .en_i          (state_q == RX_DATA && dv_q),
      .nibble_i      (rxd_q),
      .crc_o         (),
      .residue_ok_o  (residue_ok)
   );

   // Each completed byte, FCS included, goes to its lane
   assign wr_en_o   = (state_q == RX_DATA) && dv_q && hi_phase_q;
   assign wr_be_o   = 4'b0001 << byte_cnt_q[1:0];
   assign wr_addr_o = byte_cnt_q[BUF_ADDR_W-1:2];
   assign wr_data_o = {24'h0, rxd_q, lo_nib_q} << (8*byte_cnt_q[1:0]);
   assign size_o    = byte_cnt_q;

   always_ff @(posedge MRxClk or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         rxd_q     <= '0;
         dv_q      <= 1'b0;
         dv_d      <= 1'b0;
         dv_seen_o <= 1'b0;
      end else begin
         rxd_q     <= mrxd_i;
         dv_q      <= mrx_dv_i;
         dv_d      <= dv_q;
         dv_seen_o <= dv_seen_o | dv_q;   // Sticky
      end
   end

   always_ff @(posedge MRxClk or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         state_q    <= RX_IDLE;
         lo_nib_q   <= '0;
         hi_phase_q <= 1'b0;
         byte_cnt_q <= '0;
         rcvd_o     <= 1'b0;
         crc_err_o  <= 1'b0;
      end else begin
         case (state_q)
            RX_IDLE: if (dv_q && !dv_d) state_q <= RX_PREAMBLE;   // Only a fresh frame
            RX_PREAMBLE: begin
               if (!dv_q) begin
                  state_q <= RX_IDLE;
               end else if (rxd_q == SFD_NIBBLE) begin
                  state_q    <= RX_DATA;
                  byte_cnt_q <= '0;
                  hi_phase_q <= 1'b0;
               end
            end
            RX_DATA: begin
               if (!dv_q) begin
                  state_q   <= RX_HOLD;
                  rcvd_o    <= 1'b1;
                  crc_err_o <= !residue_ok;
               end else begin
                  hi_phase_q <= !hi_phase_q;
                  if (!hi_phase_q) lo_nib_q <= rxd_q;
                  else byte_cnt_q <= byte_cnt_q + 1'b1;
               end
            end
            RX_HOLD: begin
               if (ack_i) begin
                  state_q   <= RX_IDLE;
                  rcvd_o    <= 1'b0;
                  crc_err_o <= 1'b0;
               end
            end
            default: state_q <= RX_IDLE;
         endcase
      end
   end

endmodule

//--- rtl/eth_csr.sv
`timescale 1ns/1ps

module eth_csr (
   input  logic                                   MRxClk,
   input  logic                                   ETH_PHY_RESETN,
   input  logic                                   wb_cyc_i,
   input  logic                                   wb_stb_i,
   input  logic                                   wb_we_i,
   input  logic [eth_csr_pkg::WB_ADR_W-1:0]       wb_adr_i,
   input  logic [31:0]                            wb_dat_i,
   input  logic [3:0]                             wb_sel_i,
   output logic [31:0]                            wb_dat_o,
   output logic                                   wb_ack_o,
   output logic                                   send_o,
   output logic [eth_csr_pkg::BUF_WINDOW_BIT-1:0] nbytes_o,
   input  logic                                   tx_ready_i,
   output logic                                   ack_o,
   input  logic                                   rx_rcvd_i,
   input  logic                                   crc_err_i,
   input  logic                                   dv_seen_i,
   input  logic [eth_csr_pkg::BUF_WINDOW_BIT-1:0] rx_size_i,
   output logic                                   txb_wr_en_o,
   output logic [3:0]                             txb_be_o,
   output logic [eth_csr_pkg::BUF_WINDOW_BIT-3:0] txb_addr_o,
   output logic [31:0]                            txb_data_o,
   output logic [eth_csr_pkg::BUF_WINDOW_BIT-3:0] rxb_addr_o,
   input  logic [31:0]                            rxb_data_i
);
   import eth_csr_pkg::*;

   csr_addr_t   reg_addr;
   logic        pend_q;    // Access seen, ack follows on the next edge
   logic        window;
   logic        wr_stb;
   logic        ctrl_wr;
   logic [31:0] status;
   logic [31:0] rd_data;

   assign reg_addr = csr_addr_t'(wb_adr_i);
   assign window   = wb_adr_i[BUF_WINDOW_BIT];
   assign wr_stb   = pend_q && wb_cyc_i && wb_stb_i && wb_we_i;
   assign ctrl_wr  = wr_stb && !window && (reg_addr == CSR_CTRL);

   assign send_o = ctrl_wr && wb_dat_i[CTRL_SEND_BIT] && tx_ready_i;   // Ignored while busy
   assign ack_o  = ctrl_wr && wb_dat_i[CTRL_ACK_BIT];

   // TX buffer write port
   assign txb_wr_en_o = wr_stb && window;
   assign txb_be_o    = wb_sel_i;
   assign txb_addr_o  = wb_adr_i[BUF_WINDOW_BIT-1:2];
   assign txb_data_o  = wb_dat_i;

   // RX buffer read starts in the stb cycle
   assign rxb_addr_o = wb_adr_i[BUF_WINDOW_BIT-1:2];

   always_comb begin
      status = '0;
      status[STAT_TX_READY] = tx_ready_i;
      status[STAT_RX_RCVD]  = rx_rcvd_i;
      status[STAT_CRC_ERR]  = crc_err_i;
      status[STAT_DV_SEEN]  = dv_seen_i;
      status[STAT_SIZE_LSB +: BUF_WINDOW_BIT] = rx_size_i;
   end

   always_comb begin
      if (window) begin
         rd_data = rxb_data_i;
      end else begin
         case (reg_addr)
            CSR_TX_NBYTES: rd_data = 32'(nbytes_o);
            CSR_STATUS:    rd_data = status;
            default:       rd_data = '0;   // CTRL reads as zero
         endcase
      end
   end

   always_ff @(posedge MRxClk or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         pend_q   <= 1'b0;
         wb_ack_o <= 1'b0;
         nbytes_o <= '0;
      end else begin
         pend_q   <= wb_cyc_i && wb_stb_i && !pend_q && !wb_ack_o;
         wb_ack_o <= pend_q;
         if (wr_stb && !window && reg_addr == CSR_TX_NBYTES) begin
            nbytes_o <= wb_dat_i[BUF_WINDOW_BIT-1:0];
         end
      end
   end

   always_ff @(posedge MRxClk) begin
      if (pend_q) wb_dat_o <= rd_data;
   end

endmodule

//--- rtl/eth_core.sv
`timescale 1ns/1ps

module eth_core (
   input  logic                             MRxClk,
   input  logic                             ETH_PHY_RESETN,
   input  logic                             wb_cyc_i,
   input  logic                             wb_stb_i,
   input  logic                             wb_we_i,
   input  logic [eth_csr_pkg::WB_ADR_W-1:0] wb_adr_i,
   input  logic [31:0]                      wb_dat_i,
   input  logic [3:0]                       wb_sel_i,
   output logic [31:0]                      wb_dat_o,
   output logic                             wb_ack_o,
   output logic [3:0]                       mtxd_o,
   output logic                             mtx_en_o,
   input  logic [3:0]                       mrxd_i,
   input  logic                             mrx_dv_i
);
   import eth_frame_pkg::*;

   logic                  send;
   logic                  tx_ready;
   logic [BUF_ADDR_W-1:0] tx_nbytes;
   logic                  rx_ack;
   logic                  rx_rcvd;
   logic                  crc_err;
   logic                  dv_seen;
   logic [BUF_ADDR_W-1:0] rx_size;

   // Host side of TX buffer, MAC side of RX buffer
   logic                  txb_wr_en;
   logic [3:0]            txb_be;
   logic [BUF_ADDR_W-3:0] txb_wr_addr;
   logic [31:0]           txb_wr_data;
   logic [BUF_ADDR_W-3:0] txb_rd_addr;
   logic [31:0]           txb_rd_data;
   logic                  rxb_wr_en;
   logic [3:0]            rxb_be;
   logic [BUF_ADDR_W-3:0] rxb_wr_addr;
   logic [31:0]           rxb_wr_data;
   logic [BUF_ADDR_W-3:0] rxb_rd_addr;
   logic [31:0]           rxb_rd_data;

   eth_csr i_csr (
      .MRxClk, .ETH_PHY_RESETN,
      .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_sel_i, .wb_dat_o, .wb_ack_o,
      .send_o(send), .nbytes_o(tx_nbytes), .tx_ready_i(tx_ready), .ack_o(rx_ack),
      .rx_rcvd_i(rx_rcvd), .crc_err_i(crc_err), .dv_seen_i(dv_seen), .rx_size_i(rx_size),
      .txb_wr_en_o(txb_wr_en), .txb_be_o(txb_be), .txb_addr_o(txb_wr_addr),
      .txb_data_o(txb_wr_data), .rxb_addr_o(rxb_rd_addr), .rxb_data_i(rxb_rd_data)
   );

   eth_buffer_ram tx_buffer (
      .MRxClk, .wr_en_i(txb_wr_en), .wr_be_i(txb_be), .wr_addr_i(txb_wr_addr),
      .wr_data_i(txb_wr_data), .rd_addr_i(txb_rd_addr), .rd_data_o(txb_rd_data)
   );

   eth_tx i_tx (
      .MRxClk, .ETH_PHY_RESETN, .send_i(send), .nbytes_i(tx_nbytes), .ready_o(tx_ready),
      .buf_addr_o(txb_rd_addr), .buf_data_i(txb_rd_data), .mtxd_o, .mtx_en_o
   );

   eth_rx i_rx (
      .MRxClk, .ETH_PHY_RESETN, .mrxd_i, .mrx_dv_i, .ack_i(rx_ack),
      .wr_en_o(rxb_wr_en), .wr_be_o(rxb_be), .wr_addr_o(rxb_wr_addr), .wr_data_o(rxb_wr_data),
      .rcvd_o(rx_rcvd), .crc_err_o(crc_err), .dv_seen_o(dv_seen), .size_o(rx_size)
   );

   eth_buffer_ram rx_buffer (
      .MRxClk, .wr_en_i(rxb_wr_en), .wr_be_i(rxb_be), .wr_addr_i(rxb_wr_addr),
      .wr_data_i(rxb_wr_data), .rd_addr_i(rxb_rd_addr), .rd_data_o(rxb_rd_data)
   );

endmodule

//--- tb/eth_core_tb.sv
`timescale 1ns/1ps

module eth_core_tb;
   import eth_frame_pkg::*;
   import eth_csr_pkg::*;

   typedef logic [7:0] byte_q_t [$];

   logic        MRxClk;
   logic        ETH_PHY_RESETN;
   logic        wb_cyc, wb_stb, wb_we, wb_ack_o;
   logic [11:0] wb_adr;
   logic [31:0] wb_dat, wb_dat_o;
   logic [3:0]  wb_sel, mtxd_o, inj_d;
   logic        mtx_en_o, inj_dv, use_loopback;
   logic [3:0]  exp_nibbles [$];
   logic [3:0]  got_nibbles [$];
   int          error_count = 0;
   int          frames_sent = 0;
   int          frames_injected = 0;
   int          frames_seen = 0;

   eth_core i_eth_core (
      .MRxClk, .ETH_PHY_RESETN,
      .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
      .wb_dat_i(wb_dat), .wb_sel_i(wb_sel), .wb_dat_o, .wb_ack_o, .mtxd_o, .mtx_en_o,
      .mrxd_i(use_loopback ? mtxd_o : inj_d), .mrx_dv_i(use_loopback ? mtx_en_o : inj_dv)
   );

   initial begin
      MRxClk = 1'b0;
      forever #20 MRxClk = ~MRxClk;
   end

   // Five frames of at most 3000 cycles each
   initial begin
      #(5 * 3000 * 40);
      $display("Watchdog expired before the tests finished");
      $display("Some tests failed");
      $finish;
   end

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
      error_count++;
   endtask

   // Reflected CRC-32 over whole bytes fed LSB first
   function automatic logic [31:0] ref_fcs(input byte_q_t data);
      logic [31:0] crc;
      crc = CRC_INIT;
      foreach (data[i]) begin
         crc ^= {24'h0, data[i]};
         for (int b = 0; b < 8; b++) crc = crc[0] ? (crc >> 1) ^ 32'hEDB8_8320 : crc >> 1;
      end
      return ~crc;
   endfunction

   function automatic byte_q_t with_fcs(input byte_q_t data);
      byte_q_t     frame;
      logic [31:0] fcs;
      frame = data;
      fcs   = ref_fcs(data);
      for (int b = 0; b < FCS_BYTES; b++) frame.push_back(fcs[8*b +: 8]);
      return frame;
   endfunction

   function automatic byte_q_t random_bytes(input int n);
      byte_q_t q;
      for (int i = 0; i < n; i++) q.push_back(8'($urandom()));
      return q;
   endfunction

   task automatic bus_cycle(input logic we, input logic [11:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, output logic [31:0] rdat);
      int cycles;
      @(posedge MRxClk);
      #1;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we  = we;
      wb_adr = adr;
      wb_dat = dat;
      wb_sel = sel;
      cycles = 0;
      do begin
         @(posedge MRxClk);
         #1;
         cycles++;
      end while (wb_ack_o !== 1'b1 && cycles < 10);
      if (wb_ack_o !== 1'b1) begin
         $display("Wishbone access at 0x%03h got no ack", adr);
         error_count++;
      end else if (cycles != 2) begin
         report_mismatch("wb_ack_o delay", cycles, 32'd2);
      end
      rdat   = wb_dat_o;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic write_word(input logic [11:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel);
      logic [31:0] unused;
      bus_cycle(1'b1, adr, dat, sel, unused);
   endtask

   task automatic read_word(input logic [11:0] adr, output logic [31:0] dat);
      bus_cycle(1'b0, adr, 32'h0, 4'hF, dat);
   endtask

   task automatic check_status(input logic ready, input logic rcvd, input logic err,
                               input logic dv, input int size);
      logic [31:0] st;
      repeat (2) @(posedge MRxClk);   // Verdict settles 2 cycles after frame end
      read_word(CSR_STATUS, st);
      if (st[STAT_TX_READY] !== ready) report_mismatch("tx_ready", 32'(st[0]), 32'(ready));
      if (st[STAT_RX_RCVD] !== rcvd) report_mismatch("rx_rcvd", 32'(st[1]), 32'(rcvd));
      if (st[STAT_CRC_ERR] !== err) report_mismatch("crc_err", 32'(st[2]), 32'(err));
      if (st[STAT_DV_SEEN] !== dv) report_mismatch("dv_seen", 32'(st[3]), 32'(dv));
      if (size >= 0 && st[STAT_SIZE_LSB +: 11] !== 11'(size)) begin
         report_mismatch("rx_size", 32'(st[STAT_SIZE_LSB +: 11]), 32'(size));
      end
   endtask

   task automatic check_rx_buffer(input byte_q_t exp);
      logic [31:0] word;
      for (int w = 0; w < (exp.size() + 3) / 4; w++) begin
         read_word(12'((1 << BUF_WINDOW_BIT) + 4 * w), word);
         for (int b = 0; b < 4; b++) begin
            if (4 * w + b < exp.size() && word[8*b +: 8] !== exp[4*w + b]) begin
               report_mismatch("rx buffer byte", 32'(word[8*b +: 8]), 32'(exp[4*w + b]));
            end
         end
      end
   endtask

   task automatic ack_frame();
      write_word(CSR_CTRL, 32'(1 << CTRL_ACK_BIT), 4'hF);
   endtask

   // Loads the TX buffer with odd words byte by byte and sends it
   task automatic transmit_frame(input byte_q_t payload);
      byte_q_t     wire_bytes;
      logic [31:0] word;
      logic [31:0] lane_word;
      int          seen;
      int          cycles;
      for (int w = 0; w < (payload.size() + 3) / 4; w++) begin
         word = $urandom();
         for (int b = 0; b < 4; b++) begin
            if (4 * w + b < payload.size()) word[8*b +: 8] = payload[4*w + b];
         end
         if (w % 2 == 0) begin
            write_word(12'((1 << BUF_WINDOW_BIT) + 4 * w), word, 4'hF);
         end else begin
            for (int b = 0; b < 4; b++) begin
               lane_word = $urandom();   // Other lanes carry junk that sel must mask
               lane_word[8*b +: 8] = word[8*b +: 8];
               write_word(12'((1 << BUF_WINDOW_BIT) + 4 * w), lane_word, 4'(1 << b));
            end
         end
      end
      write_word(CSR_TX_NBYTES, 32'(payload.size()), 4'hF);
      read_word(CSR_TX_NBYTES, word);
      if (word !== 32'(payload.size())) report_mismatch("TX_NBYTES", word, 32'(payload.size()));
      wire_bytes = with_fcs(payload);
      exp_nibbles.delete();
      for (int i = 0; i < PREAMBLE_NIBBLES; i++) exp_nibbles.push_back(4'h5);
      exp_nibbles.push_back(SFD_NIBBLE);
      foreach (wire_bytes[i]) begin
         exp_nibbles.push_back(wire_bytes[i][3:0]);
         exp_nibbles.push_back(wire_bytes[i][7:4]);
      end
      seen = frames_seen;
      write_word(CSR_CTRL, 32'(1 << CTRL_SEND_BIT), 4'hF);
      frames_sent++;
      cycles = 0;
      while (mtx_en_o !== 1'b1 && cycles < 10) begin
         @(posedge MRxClk);
         #1;
         cycles++;
      end
      if (cycles > 3) report_mismatch("mtx_en_o start delay", cycles, 32'd3);
      read_word(CSR_STATUS, word);
      if (word[STAT_TX_READY] !== 1'b0) begin
         report_mismatch("tx_ready in frame", 32'(word[STAT_TX_READY]), 32'h0);
      end
      cycles = 0;
      while (frames_seen == seen && cycles < 3000) begin
         @(posedge MRxClk);
         cycles++;
      end
      if (frames_seen == seen) begin
         $display("Transmit frame did not end in time");
         error_count++;
      end
   endtask

   // Preamble and delimiter followed by each byte low nibble first
   task automatic inject_frame(input byte_q_t frame);
      @(posedge MRxClk);
      #1;
      use_loopback = 1'b0;
      for (int i = 0; i < 2 * frame.size() + 16; i++) begin
         inj_dv = 1'b1;
         if (i < 15) inj_d = 4'h5;
         else if (i == 15) inj_d = SFD_NIBBLE;
         else inj_d = (i % 2 == 0) ? frame[(i-16)/2][3:0] : frame[(i-16)/2][7:4];
         @(posedge MRxClk);
         #1;
      end
      inj_dv = 1'b0;
      inj_d  = 4'h0;
      use_loopback = 1'b1;
      frames_injected++;
   endtask

   // Collects one frame per mtx_en_o burst and compares it
   initial begin
      forever begin
         @(negedge MRxClk);
         if (mtx_en_o === 1'b1) begin
            got_nibbles.push_back(mtxd_o);
         end else if (got_nibbles.size() > 0) begin
            if (got_nibbles.size() != exp_nibbles.size()) begin
               report_mismatch("mtx_en_o high cycles", got_nibbles.size(), exp_nibbles.size());
            end else begin
               foreach (got_nibbles[i]) begin
                  if (got_nibbles[i] !== exp_nibbles[i]) begin
                     report_mismatch("mtxd_o", 32'(got_nibbles[i]), 32'(exp_nibbles[i]));
                  end
               end
            end
            got_nibbles.delete();
            frames_seen++;
         end
      end
   end

   initial begin
      byte_q_t frame;
      byte_q_t held;
      int      n;
      ETH_PHY_RESETN = 1'b0;
      {wb_cyc, wb_stb, wb_we, wb_adr, wb_dat, wb_sel} = '0;
      inj_d = 4'h0;
      inj_dv = 1'b0;
      use_loopback = 1'b1;
      void'($urandom(53));
      repeat (3) @(posedge MRxClk);
      #1;
      ETH_PHY_RESETN = 1'b1;

      if (mtx_en_o !== 1'b0) report_mismatch("mtx_en_o", 32'(mtx_en_o), 32'h0);
      check_status(1'b1, 1'b0, 1'b0, 1'b0, 0);

      // Loopback frames with the first one of odd length
      for (int k = 0; k < 2; k++) begin
         n = (k == 0) ? int'($urandom_range(29, 0)) * 2 + 1 : int'($urandom_range(60, 1));
         frame = random_bytes(n);
         transmit_frame(frame);
         check_status(1'b1, 1'b1, 1'b0, 1'b1, n + FCS_BYTES);
         check_rx_buffer(with_fcs(frame));
         if (k == 0) ack_frame();
         held = with_fcs(frame);
      end

      // Frame arriving while one is held
      inject_frame(with_fcs(random_bytes(24)));
      check_status(1'b1, 1'b1, 1'b0, 1'b1, held.size());
      check_rx_buffer(held);
      ack_frame();
      check_status(1'b1, 1'b0, 1'b0, 1'b1, -1);

      frame = with_fcs(random_bytes(17));
      frame[frame.size() - 2] = ~frame[frame.size() - 2];
      inject_frame(frame);
      check_status(1'b1, 1'b1, 1'b1, 1'b1, frame.size());
      ack_frame();
      frame = with_fcs(random_bytes(33));
      inject_frame(frame);
      check_status(1'b1, 1'b1, 1'b0, 1'b1, frame.size());
      check_rx_buffer(frame);
      ack_frame();

      $display("Frames sent: %0d, injected: %0d, errors: %0d",
               frames_sent, frames_injected, error_count);
      if (error_count == 0) $display("All tests passed");
      else $display("Some tests failed");
      $finish;
   end

endmodule

//--- all.f
rtl/eth_frame_pkg.sv
rtl/eth_csr_pkg.sv
rtl/eth_crc32.sv
rtl/eth_buffer_ram.sv
rtl/eth_tx.sv
rtl/eth_rx.sv
rtl/eth_csr.sv
rtl/eth_core.sv
tb/eth_core_tb.sv

//--- Makefile
TOP := eth_core_tb

.PHONY: all lint clean

all:
	verilator --binary --timing -f all.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir
